//--- files.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/exec_if.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/cpu_top.sv
verif/tb_cpu.sv

//--- Bender.yml
package:
  name: mips_int_core

sources:
  - logic/isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/exec_if.sv
  - logic/reg_file.sv
  - logic/forward_unit.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/cpu_top.sv
  - target: simulation
    files:
      - verif/tb_cpu.sv

//--- verif/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int reset_cycles = 2;
    localparam int drain_margin = 20;

    logic        in_clk;
    logic        in_rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    reg_addr_t   wb_addr;
    word_t       wb_data;

    // Program built up front, then streamed one slot per cycle
    logic [31:0] prog_word [$];
    bit          prog_valid [$];
    string       prog_name [$];

    // Expected writes in issue order
    int          exp_due [$];
    result_t     exp_res [$];
    string       exp_name [$];

    word_t       model_regs [32];
    logic [5:0]  fn_pick [11];
    logic [5:0]  op_pick [7];
    int          cycle = 0;
    int          limit = 1000000;
    int          errors = 0;
    int          checks = 0;
    string       cur_name = "reset";

    cpu_top dut (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    always #4 in_clk = ~in_clk;

    function automatic logic [31:0] rtype_word(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                               reg_addr_t rd, logic [4:0] sa);
        return {op_rtype, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                               logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // In-order ISA model; r0 is never written so it stays zero
    function automatic result_t ref_exec(input logic [31:0] ins, ref word_t regs [32]);
        result_t    r;
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sa;
        word_t      a;
        word_t      b;
        word_t      imm_s;
        word_t      imm_z;
        op = ins[31:26];
        fn = ins[5:0];
        sa = ins[10:6];
        a = regs[ins[25:21]];
        b = regs[ins[20:16]];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        imm_z = {16'h0000, ins[15:0]};
        r.valid = 1'b1;
        r.addr = ins[20:16];
        r.data = '0;
        // Signed compares done as unsigned compares in offset binary
        case (op)
            op_rtype:
            begin
                r.addr = ins[15:11];
                case (fn)
                    fn_addu: r.data = a + b;
                    fn_subu: r.data = a - b;
                    fn_and:  r.data = a & b;
                    fn_or:   r.data = a | b;
                    fn_xor:  r.data = a ^ b;
                    fn_nor:  r.data = ~(a | b);
                    fn_slt:  r.data = ((a ^ 32'h80000000) < (b ^ 32'h80000000)) ? 32'd1 : 32'd0;
                    fn_sltu: r.data = (a < b) ? 32'd1 : 32'd0;
                    fn_sll:  r.data = b << sa;
                    fn_srl:  r.data = b >> sa;
                    fn_sra:  r.data = (b >> sa) | (b[31] ? ~(32'hffffffff >> sa) : 32'd0);
                    default: r.valid = 1'b0;
                endcase
            end
            op_addiu: r.data = a + imm_s;
            op_slti:  r.data = ((a ^ 32'h80000000) < (imm_s ^ 32'h80000000)) ? 32'd1 : 32'd0;
            op_andi:  r.data = a & imm_z;
            op_ori:   r.data = a | imm_z;
            op_xori:  r.data = a ^ imm_z;
            op_lui:   r.data = {ins[15:0], 16'h0000};
            default:  r.valid = 1'b0;
        endcase
        if (r.addr == '0)
        begin
            r.valid = 1'b0;
        end
        if (r.valid)
        begin
            regs[r.addr] = r.data;
        end
        return r;
    endfunction

    task automatic issue(string name, logic [31:0] word);
        prog_word.push_back(word);
        prog_valid.push_back(1'b1);
        prog_name.push_back(name);
    endtask

    // Idle slots carry junk words that must be ignored
    task automatic gap(string name, int n);
        for (int i = 0; i < n; i++)
        begin
            prog_word.push_back($urandom);
            prog_valid.push_back(1'b0);
            prog_name.push_back(name);
        end
    endtask

    task automatic build_program();
        string      t;
        int         kind;
        logic [31:0] w;
        gap("idle after reset", 5);

        t = "directed ops";
        issue(t, itype_word(op_lui, 0, 1, 16'h8000));
        issue(t, itype_word(op_ori, 1, 1, 16'h0005));
        issue(t, itype_word(op_addiu, 0, 2, 16'hfffd));
        issue(t, itype_word(op_ori, 0, 3, 16'hfffd));
        issue(t, itype_word(op_addiu, 0, 4, 16'h0007));
        issue(t, rtype_word(fn_addu, 2, 4, 5, 0));
        issue(t, rtype_word(fn_subu, 4, 2, 6, 0));
        issue(t, rtype_word(fn_and, 1, 3, 7, 0));
        issue(t, rtype_word(fn_or, 1, 3, 8, 0));
        issue(t, rtype_word(fn_xor, 1, 3, 9, 0));
        issue(t, rtype_word(fn_nor, 1, 3, 10, 0));
        issue(t, rtype_word(fn_slt, 0, 2, 4, 11));
        issue(t, rtype_word(fn_slt, 2, 4, 11, 0));
        issue(t, rtype_word(fn_sltu, 2, 4, 12, 0));
        issue(t, itype_word(op_slti, 2, 13, 16'hffff));
        issue(t, itype_word(op_slti, 4, 14, 16'hffff));
        issue(t, rtype_word(fn_sll, 0, 1, 15, 4));
        issue(t, rtype_word(fn_srl, 0, 1, 16, 4));
        issue(t, rtype_word(fn_sra, 0, 1, 17, 4));
        issue(t, itype_word(op_andi, 2, 18, 16'h8f0f));
        issue(t, itype_word(op_xori, 2, 19, 16'hffff));
        issue(t, itype_word(op_addiu, 1, 20, 16'h8000));

        // Distances 1, 2 and 3 back from the producer
        t = "dependent chain";
        issue(t, itype_word(op_addiu, 0, 21, 16'h0100));
        issue(t, itype_word(op_addiu, 21, 22, 16'h0001));
        issue(t, itype_word(op_addiu, 21, 23, 16'h0002));
        issue(t, itype_word(op_addiu, 21, 24, 16'h0003));
        issue(t, rtype_word(fn_subu, 24, 22, 25, 0));
        issue(t, rtype_word(fn_xor, 0, 25, 26, 0));
        gap(t, 1);
        issue(t, rtype_word(fn_addu, 26, 23, 26, 0));

        t = "no write cases";
        issue(t, itype_word(op_addiu, 0, 0, 16'h0005));
        issue(t, rtype_word(fn_addu, 1, 2, 0, 0));
        issue(t, itype_word(6'h3f, 1, 5, 16'h1234));
        issue(t, rtype_word(6'h01, 1, 2, 6, 0));
        gap(t, 3);
        issue(t, rtype_word(fn_addu, 0, 0, 27, 0));
        issue(t, rtype_word(fn_or, 0, 1, 28, 0));

        t = "random mix";
        for (int i = 0; i < 150; i++)
        begin
            kind = $urandom_range(17, 0);
            if (kind < 11)
            begin
                w = rtype_word(fn_pick[kind], reg_addr_t'($urandom_range(31, 0)),
                               reg_addr_t'($urandom_range(31, 0)),
                               reg_addr_t'($urandom_range(31, 0)), 5'($urandom_range(31, 0)));
            end
            else
            begin
                w = itype_word(op_pick[kind - 11], reg_addr_t'($urandom_range(31, 0)),
                               reg_addr_t'($urandom_range(31, 0)),
                               16'($urandom_range(16'hffff, 0)));
            end
            issue(t, w);
            if ($urandom_range(3, 0) == 0)
            begin
                gap(t, $urandom_range(2, 1));
            end
        end
    endtask

    initial
    begin
        result_t want;
        void'($urandom(32'h5f27e4e7));
        in_clk = 1'b0;
        in_rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        for (int i = 0; i < 32; i++)
        begin
            model_regs[i] = '0;
        end
        fn_pick = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                    fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
        op_pick = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui, op_addiu};
        build_program();
        limit = prog_word.size() + reset_cycles + drain_margin;

        repeat (reset_cycles) @(posedge in_clk);
        @(negedge in_clk);
        in_rst = 1'b0;

        for (int i = 0; i < prog_word.size(); i++)
        begin
            instr_valid = prog_valid[i];
            instr = prog_word[i];
            cur_name = prog_name[i];
            if (prog_valid[i])
            begin
                want = ref_exec(prog_word[i], model_regs);
                // Issue edge is the next rising edge, result visible two edges later
                if (want.valid)
                begin
                    exp_due.push_back(cycle + 3);
                    exp_res.push_back(want);
                    exp_name.push_back(prog_name[i]);
                end
            end
            @(negedge in_clk);
        end
        instr_valid = 1'b0;
        instr = '0;
        cur_name = "drain";

        while (exp_due.size() != 0)
        begin
            @(negedge in_clk);
        end
        repeat (3) @(negedge in_clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Outputs still hold the state after the previous edge here
    always @(posedge in_clk)
    begin
        result_t want;
        string   name;
        if (!in_rst)
        begin
            if (exp_due.size() != 0 && exp_due[0] == cycle)
            begin
                want = exp_res.pop_front();
                name = exp_name.pop_front();
                void'(exp_due.pop_front());
            end
            else
            begin
                want = '0;
                name = cur_name;
            end
            checks++;
            assert (wb_valid === want.valid)
            else
            begin
                errors++;
                $display("FAIL %s: wb_valid expected %0b actual %0b (edge %0d)",
                         name, want.valid, wb_valid, cycle);
            end
            if (want.valid)
            begin
                assert (wb_addr === want.addr)
                else
                begin
                    errors++;
                    $display("FAIL %s: wb_addr expected %0d actual %0d",
                             name, want.addr, wb_addr);
                end
                assert (wb_data === want.data)
                else
                begin
                    errors++;
                    $display("FAIL %s: wb_data expected %h actual %h",
                             name, want.data, wb_data);
                end
            end
        end
        cycle++;
        if (cycle >= limit)
        begin
            errors++;
            $display("timeout: pipeline did not drain");
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic               in_clk,
    input  logic               in_rst,
    input  logic               instr_valid,
    input  logic [31:0]        instr,
    output logic               wb_valid,
    output isa_pkg::reg_addr_t wb_addr,
    output pipe_pkg::word_t    wb_data
);

    import pipe_pkg::*;

    result_t ex_result;
    result_t wb_result;

    exec_if exe_bus ();

    decode_stage u_decode (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ex_result   (ex_result),
        .wb_result   (wb_result),
        .exe         (exe_bus.decode)
    );

    execute_stage u_execute (
        .in_clk    (in_clk),
        .in_rst    (in_rst),
        .exe       (exe_bus.execute),
        .ex_result (ex_result),
        .wb_result (wb_result)
    );

    // Register write as it leaves the pipeline
    assign wb_valid = wb_result.valid;
    assign wb_addr  = wb_result.addr;
    assign wb_data  = wb_result.data;

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              in_clk,
    input  logic              in_rst,
    exec_if.execute           exe,
    output pipe_pkg::result_t ex_result,
    output pipe_pkg::result_t wb_result
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t     alu_y;
    logic [4:0] sh;
    logic      wb_valid_q;
    reg_addr_t wb_addr_q;
    word_t     wb_data_q;

    // Shift amount in a, shifted value in b
    assign sh = exe.op_a[4:0];

    always_comb
    begin
        case (exe.alu_op)
            alu_add:  alu_y = exe.op_a + exe.op_b;
            alu_sub:  alu_y = exe.op_a - exe.op_b;
            alu_and:  alu_y = exe.op_a & exe.op_b;
            alu_or:   alu_y = exe.op_a | exe.op_b;
            alu_xor:  alu_y = exe.op_a ^ exe.op_b;
            alu_nor:  alu_y = ~(exe.op_a | exe.op_b);
            alu_slt:  alu_y = ($signed(exe.op_a) < $signed(exe.op_b)) ? word_t'(1) : '0;
            alu_sltu: alu_y = (exe.op_a < exe.op_b) ? word_t'(1) : '0;
            alu_sll:  alu_y = exe.op_b << sh;
            alu_srl:  alu_y = exe.op_b >> sh;
            alu_sra:  alu_y = word_t'($signed(exe.op_b) >>> sh);
            default:  alu_y = '0;
        endcase
    end

    assign ex_result = '{valid: exe.valid, addr: exe.dest, data: alu_y};

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            wb_valid_q <= 1'b0;
        end
        else
        begin
            wb_valid_q <= ex_result.valid;
        end
    end

    always_ff @(posedge in_clk)
    begin
        wb_addr_q <= ex_result.addr;
        wb_data_q <= ex_result.data;
    end

    assign wb_result = '{valid: wb_valid_q, addr: wb_addr_q, data: wb_data_q};

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              in_clk,
    input  logic              in_rst,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    input  pipe_pkg::result_t ex_result,
    input  pipe_pkg::result_t wb_result,
    exec_if.decode            exe
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic        fd_valid;
    logic [31:0] fd_instr;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    logic [15:0] imm;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    reg_addr_t   dest;

    alu_op_t alu_op;
    logic    known;
    logic    use_imm;
    logic    use_shamt;
    logic    use_lui;
    logic    sign_ext;
    logic    wr_valid;

    word_t rs_rf;
    word_t rt_rf;
    word_t rs_fwd;
    word_t rt_fwd;
    word_t imm_ext;
    word_t op_a;
    word_t op_b;

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            fd_valid <= 1'b0;
        end
        else
        begin
            fd_valid <= instr_valid;
        end
    end

    always_ff @(posedge in_clk)
    begin
        fd_instr <= instr;
    end

    assign opcode = fd_instr[op_hi:op_lo];
    assign funct  = fd_instr[funct_hi:funct_lo];
    assign shamt  = fd_instr[shamt_hi:shamt_lo];
    assign imm    = fd_instr[imm_hi:imm_lo];
    assign rs     = fd_instr[rs_hi:rs_lo];
    assign rt     = fd_instr[rt_hi:rt_lo];
    assign rd     = fd_instr[rd_hi:rd_lo];

    always_comb
    begin
        alu_op    = alu_add;
        known     = 1'b1;
        use_imm   = 1'b1;
        use_shamt = 1'b0;
        use_lui   = 1'b0;
        sign_ext  = 1'b1;
        dest      = rt;
        case (opcode)
            op_rtype:
            begin
                use_imm = 1'b0;
                dest    = rd;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:
                    begin
                        alu_op    = alu_sll;
                        use_shamt = 1'b1;
                    end
                    fn_srl:
                    begin
                        alu_op    = alu_srl;
                        use_shamt = 1'b1;
                    end
                    fn_sra:
                    begin
                        alu_op    = alu_sra;
                        use_shamt = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            op_addiu: alu_op = alu_add;
            op_slti:  alu_op = alu_slt;
            op_andi:
            begin
                alu_op   = alu_and;
                sign_ext = 1'b0;
            end
            op_ori:
            begin
                alu_op   = alu_or;
                sign_ext = 1'b0;
            end
            op_xori:
            begin
                alu_op   = alu_xor;
                sign_ext = 1'b0;
            end
            op_lui:
            begin
                alu_op  = alu_sll;
                use_lui = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // Unknown opcodes and writes to r0 become bubbles
    assign wr_valid = fd_valid && known && (dest != '0);

    assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'b0, imm};

    reg_file u_reg_file (
        .in_clk  (in_clk),
        .in_rst  (in_rst),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_rf),
        .rt_data (rt_rf),
        .wr      (wb_result)
    );

    forward_unit u_fwd_rs (
        .src       (rs),
        .rf_data   (rs_rf),
        .ex_result (ex_result),
        .wb_result (wb_result),
        .data      (rs_fwd)
    );

    forward_unit u_fwd_rt (
        .src       (rt),
        .rf_data   (rt_rf),
        .ex_result (ex_result),
        .wb_result (wb_result),
        .data      (rt_fwd)
    );

    always_comb
    begin
        if (use_lui)
        begin
            op_a = word_t'(lui_shift);
        end
        else if (use_shamt)
        begin
            op_a = word_t'(shamt);
        end
        else
        begin
            op_a = rs_fwd;
        end
    end

    assign op_b = use_imm ? imm_ext : rt_fwd;

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            exe.valid <= 1'b0;
        end
        else
        begin
            exe.valid <= wr_valid;
        end
    end

    always_ff @(posedge in_clk)
    begin
        exe.alu_op <= alu_op;
        exe.op_a   <= op_a;
        exe.op_b   <= op_b;
        exe.dest   <= dest;
    end

endmodule

//--- logic/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  isa_pkg::reg_addr_t src,
    input  pipe_pkg::word_t    rf_data,
    input  pipe_pkg::result_t  ex_result,
    input  pipe_pkg::result_t  wb_result,
    output pipe_pkg::word_t    data
);

    logic ex_hit;
    logic wb_hit;

    // Valid results never target register 0
    assign ex_hit = ex_result.valid && (ex_result.addr == src);
    assign wb_hit = wb_result.valid && (wb_result.addr == src);

    always_comb
    begin
        if (ex_hit)
        begin
            data = ex_result.data;
        end
        else if (wb_hit)
        begin
            // Not yet in the register file
            data = wb_result.data;
        end
        else
        begin
            data = rf_data;
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               in_clk,
    input  logic               in_rst,
    input  isa_pkg::reg_addr_t rs_addr,
    input  isa_pkg::reg_addr_t rt_addr,
    output pipe_pkg::word_t    rs_data,
    output pipe_pkg::word_t    rt_data,
    input  pipe_pkg::result_t  wr
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // Register 0 has no storage
    word_t regs [1:reg_count-1];

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            for (int i = 1; i < reg_count; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr.valid && (wr.addr != '0))
        begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- logic/exec_if.sv
`timescale 1ns/1ps

interface exec_if;

    import isa_pkg::*;
    import pipe_pkg::*;

    // High when a real instruction sits in execute
    logic      valid;
    alu_op_t   alu_op;
    word_t     op_a;
    word_t     op_b;
    reg_addr_t dest;

    modport decode (
        output valid,
        output alu_op,
        output op_a,
        output op_b,
        output dest
    );

    modport execute (
        input valid,
        input alu_op,
        input op_a,
        input op_b,
        input dest
    );

endinterface

//--- logic/pipe_pkg.sv
package pipe_pkg;

    typedef logic [isa_pkg::data_w-1:0] word_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // One register write, as seen by forwarding and the register file
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_addr_t addr;
        word_t             data;
    } result_t;

endpackage

//--- logic/isa_pkg.sv
package isa_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Instruction field positions
    localparam int op_hi    = 31;
    localparam int op_lo    = 26;
    localparam int rs_hi    = 25;
    localparam int rs_lo    = 21;
    localparam int rt_hi    = 20;
    localparam int rt_lo    = 16;
    localparam int rd_hi    = 15;
    localparam int rd_lo    = 11;
    localparam int shamt_hi = 10;
    localparam int shamt_lo = 6;
    localparam int funct_hi = 5;
    localparam int funct_lo = 0;
    localparam int imm_hi   = 15;
    localparam int imm_lo   = 0;

    // LUI is an SLL of the immediate
    localparam int lui_shift = 16;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_xori  = 6'h0e;
    localparam logic [5:0] op_lui   = 6'h0f;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

endpackage
